// File: hw/axi_transfer_controller.sv
`timescale 1ns/100ps
`include "axi_write_defs.svh"

module axi_transfer_controller (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  axi_write_pkg::addr_t  address_i,
   input  axi_write_pkg::slen_t  length_i,
   input  logic                  start_i,
   input  logic                  burst_start_i,
   output axi_write_pkg::addr_t  burst_addr_o,
   output axi_write_pkg::axlen_t burst_len_o,
   output axi_write_pkg::strb_t  first_strb_o,
   output axi_write_pkg::strb_t  last_strb_o,
   output axi_write_pkg::slen_t  word_count_o,
   output logic                  extra_beat_o,
   output logic                  last_burst_o,
   output logic                  last_burst_next_o
);

   localparam int CNT_W      = `AW_SLEN_W + 1;  // Room for offset plus length
   localparam int BOUND_BITS = $clog2(`AW_BOUNDARY);
   localparam int BEAT_SHIFT = `AW_OFFSET_W;

   // Request decode, sampled on start_i
   axi_write_pkg::offset_t start_offset;
   axi_write_pkg::offset_t end_lane;
   logic [CNT_W-1:0]       span_bytes;
   logic [CNT_W-1:0]       total_beats;
   logic [CNT_W-1:0]       src_words;
   axi_write_pkg::strb_t   head_strb;
   axi_write_pkg::strb_t   tail_strb;

   // Burst walk
   axi_write_pkg::addr_t   cur_addr_q;
   logic [CNT_W-1:0]       remaining_q;
   logic                   final_issued_q;
   logic [BOUND_BITS:0]    bound_bytes;
   logic [CNT_W-1:0]       bound_beats;
   logic [CNT_W-1:0]       burst_beats;

   axi_write_pkg::strb_t   first_strb_q;
   axi_write_pkg::strb_t   last_strb_q;
   axi_write_pkg::slen_t   word_count_q;
   logic                   extra_q;

   assign start_offset = address_i[`AW_OFFSET_W-1:0];
   assign span_bytes   = CNT_W'(length_i) + CNT_W'(start_offset);
   assign end_lane     = span_bytes[`AW_OFFSET_W-1:0];

   // Bus beats covering offset plus length, against source words
   assign total_beats = (span_bytes + CNT_W'(`AW_STRB_W - 1)) >> BEAT_SHIFT;
   assign src_words   = (CNT_W'(length_i) + CNT_W'(`AW_STRB_W - 1)) >> BEAT_SHIFT;

   always_comb begin
      for (int i = 0; i < `AW_STRB_W; i++) begin
         head_strb[i] = (i >= start_offset);
         tail_strb[i] = (end_lane == '0) || (i < end_lane);
      end
      // Single beat request, both edges on the same word
      if (total_beats == CNT_W'(1)) begin
         head_strb = head_strb & tail_strb;
      end
   end

   // Beats left before the next boundary
   assign bound_bytes = (BOUND_BITS + 1)'(`AW_BOUNDARY) -
                        {1'b0, cur_addr_q[BOUND_BITS-1:0]};
   assign bound_beats = CNT_W'(bound_bytes >> BEAT_SHIFT);

   always_comb begin
      burst_beats = CNT_W'(`AW_MAX_BEATS);
      if (remaining_q < burst_beats) begin
         burst_beats = remaining_q;
      end
      if (bound_beats < burst_beats) begin
         burst_beats = bound_beats;
      end
   end

   assign burst_addr_o      = cur_addr_q;
   assign burst_len_o       = axi_write_pkg::axlen_t'(burst_beats - CNT_W'(1));
   assign last_burst_o      = (remaining_q == burst_beats);
   assign last_burst_next_o = final_issued_q;  // Burst in flight is the final one
   assign first_strb_o      = first_strb_q;
   assign last_strb_o       = last_strb_q;
   assign word_count_o      = word_count_q;
   assign extra_beat_o      = extra_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         remaining_q    <= '0;
         final_issued_q <= 1'b0;
      end else if (start_i) begin
         remaining_q    <= total_beats;
         final_issued_q <= 1'b0;
      end else if (burst_start_i) begin
         remaining_q    <= remaining_q - burst_beats;
         final_issued_q <= last_burst_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         // Bursts run on word aligned addresses, strobes cover the edges
         cur_addr_q   <= address_i & ~axi_write_pkg::addr_t'(`AW_STRB_W - 1);
         first_strb_q <= head_strb;
         last_strb_q  <= tail_strb;
         word_count_q <= axi_write_pkg::slen_t'(src_words);
         extra_q      <= (total_beats > src_words);
      end else if (burst_start_i) begin
         cur_addr_q <= cur_addr_q + (axi_write_pkg::addr_t'(burst_beats) << BEAT_SHIFT);
      end
   end

endmodule

// File: hw/axi_write_defs.svh
`ifndef AXI_WRITE_DEFS_SVH
`define AXI_WRITE_DEFS_SVH

// Bus geometry
`define AW_ADDR_W    32
`define AW_DATA_W    32

// AXI awlen field width
`define AW_LEN_W     8

// Byte length on the simple port
`define AW_SLEN_W    12

// Burst limits
`define AW_MAX_BEATS 16
`define AW_BOUNDARY  4096  // Bursts never cross this many bytes

// Derived from the data width
`define AW_STRB_W    (`AW_DATA_W / 8)
`define AW_OFFSET_W  $clog2(`AW_STRB_W)  // Byte lane index width

`endif

// File: hw/axi_write_pkg.sv
`include "axi_write_defs.svh"

package axi_write_pkg;

   typedef logic [`AW_ADDR_W-1:0]   addr_t;    // Byte address
   typedef logic [`AW_DATA_W-1:0]   data_t;    // One bus word
   typedef logic [`AW_STRB_W-1:0]   strb_t;    // Byte enables
   typedef logic [`AW_SLEN_W-1:0]   slen_t;    // Request length in bytes
   typedef logic [`AW_LEN_W-1:0]    axlen_t;   // Beats minus one
   typedef logic [`AW_OFFSET_W-1:0] offset_t;  // Lane within a word

   // Write path sequencing
   typedef enum logic [1:0] {
      IDLE,  // Waiting for a request
      CALC,  // Controller outputs settle, awlen captured
      ADDR,  // awvalid up, waiting for awready
      DATA   // W beats of the current burst
   } wr_state_e;

endpackage

// File: hw/byte_realign.sv
`timescale 1ns/100ps
`include "axi_write_defs.svh"

module byte_realign (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  axi_write_pkg::offset_t offset_i,
   input  axi_write_pkg::data_t   data_i,
   input  logic                   advance_i,
   output axi_write_pkg::data_t   data_o
);

   // Source word moved up by the lane offset with the spill in the top half
   logic [2*`AW_DATA_W-1:0] shifted;
   axi_write_pkg::data_t    carry_q;
   axi_write_pkg::data_t    carry_mask;

   assign shifted = {{`AW_DATA_W{1'b0}}, data_i} << {offset_i, 3'b000};

   // Carried bytes only ever land below the offset
   assign carry_mask = ~({`AW_DATA_W{1'b1}} << {offset_i, 3'b000});

   // Low lanes come from the previous word
   assign data_o = shifted[`AW_DATA_W-1:0] | (carry_q & carry_mask);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         carry_q <= '0;
      end else if (advance_i) begin
         carry_q <= shifted[2*`AW_DATA_W-1:`AW_DATA_W];  // Zero at offset 0
      end
   end

endmodule

// File: hw/simple_axi_write.sv
`timescale 1ns/100ps
`include "axi_write_defs.svh"

module simple_axi_write (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  m_wvalid_i,
   input  axi_write_pkg::addr_t  m_waddr_i,
   input  axi_write_pkg::slen_t  m_wlen_i,
   input  axi_write_pkg::data_t  m_wdata_i,
   output logic                  m_wready_o,
   output logic                  m_wlast_o,
   output axi_write_pkg::addr_t  axi_awaddr_o,
   output axi_write_pkg::axlen_t axi_awlen_o,
   output logic [2:0]            axi_awsize_o,
   output logic [1:0]            axi_awburst_o,
   output logic                  axi_awvalid_o,
   input  logic                  axi_awready_i,
   output axi_write_pkg::data_t  axi_wdata_o,
   output axi_write_pkg::strb_t  axi_wstrb_o,
   output logic                  axi_wlast_o,
   output logic                  axi_wvalid_o,
   input  logic                  axi_wready_i
);

   axi_write_pkg::wr_state_e state_q;
   axi_write_pkg::axlen_t    awlen_q;
   axi_write_pkg::axlen_t    beat_cnt_q;
   axi_write_pkg::strb_t     wstrb_q;
   axi_write_pkg::offset_t   offset_q;
   logic                     awvalid_q;
   logic                     first_burst_q;

   // Controller results
   axi_write_pkg::axlen_t    burst_len;
   axi_write_pkg::strb_t     first_strb;
   axi_write_pkg::strb_t     last_strb;
   axi_write_pkg::slen_t     word_count;
   logic                     extra_beat;
   logic                     last_burst;
   logic                     last_burst_next;

   logic                     start;
   logic                     aw_fire;
   logic                     w_fire;
   logic                     in_data;
   logic                     pass_valid;
   logic                     gate_done;

   assign start   = (state_q == axi_write_pkg::IDLE) && m_wvalid_i;
   assign aw_fire = awvalid_q & axi_awready_i;
   assign in_data = (state_q == axi_write_pkg::DATA);
   assign w_fire  = axi_wvalid_o & axi_wready_i;

   axi_transfer_controller axi_transfer_controller_i (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .address_i         (m_waddr_i),
      .length_i          (m_wlen_i),
      .start_i           (start),
      .burst_start_i     (aw_fire),
      .burst_addr_o      (axi_awaddr_o),
      .burst_len_o       (burst_len),
      .first_strb_o      (first_strb),
      .last_strb_o       (last_strb),
      .word_count_o      (word_count),
      .extra_beat_o      (extra_beat),
      .last_burst_o      (last_burst),
      .last_burst_next_o (last_burst_next)
   );

   // Source words only move during W beats
   word_count_gate word_count_gate_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .count_i      (word_count),
      .load_i       (aw_fire && first_burst_q),  // Whole request counted once
      .src_valid_i  (m_wvalid_i),
      .sink_ready_i (in_data && axi_wready_i),
      .src_ready_o  (m_wready_o),
      .pass_valid_o (pass_valid),
      .last_o       (m_wlast_o),
      .done_o       (gate_done)
   );

   byte_realign byte_realign_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .offset_i  (offset_q),
      .data_i    (m_wdata_i),
      .advance_i (w_fire),
      .data_o    (axi_wdata_o)
   );

   assign axi_awsize_o  = 3'(`AW_OFFSET_W);  // Full bus width
   assign axi_awburst_o = 2'b01;             // INCR
   assign axi_awlen_o   = awlen_q;
   assign axi_awvalid_o = awvalid_q;
   assign axi_wstrb_o   = wstrb_q;

   // Extra beat drains the carried bytes once the source is exhausted
   assign axi_wvalid_o = in_data && (pass_valid || (gate_done && extra_beat));
   assign axi_wlast_o  = in_data && (beat_cnt_q == awlen_q);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q       <= axi_write_pkg::IDLE;
         awlen_q       <= '0;
         beat_cnt_q    <= '0;
         awvalid_q     <= 1'b0;
         first_burst_q <= 1'b0;
      end else begin
         case (state_q)
            axi_write_pkg::IDLE: begin
               if (m_wvalid_i) begin
                  first_burst_q <= 1'b1;
                  state_q       <= axi_write_pkg::CALC;
               end
            end
            axi_write_pkg::CALC: begin
               awlen_q   <= burst_len;
               awvalid_q <= 1'b1;
               state_q   <= axi_write_pkg::ADDR;
            end
            axi_write_pkg::ADDR: begin
               if (axi_awready_i) begin
                  awvalid_q     <= 1'b0;
                  first_burst_q <= 1'b0;
                  beat_cnt_q    <= '0;
                  state_q       <= axi_write_pkg::DATA;
               end
            end
            axi_write_pkg::DATA: begin
               if (w_fire) begin
                  beat_cnt_q <= beat_cnt_q + 1'b1;
                  if (axi_wlast_o) begin
                     // Next burst or back to idle
                     if (last_burst_next) begin
                        state_q <= axi_write_pkg::IDLE;
                     end else begin
                        state_q <= axi_write_pkg::CALC;
                     end
                  end
               end
            end
            default: state_q <= axi_write_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == axi_write_pkg::CALC) && first_burst_q) begin
         offset_q <= m_waddr_i[`AW_OFFSET_W-1:0];
      end

      // Strobe for the beat about to go out
      if (aw_fire) begin
         if (first_burst_q) begin
            wstrb_q <= first_strb;
         end else if ((awlen_q == '0) && last_burst) begin
            wstrb_q <= last_strb;  // Final burst of a single beat
         end else begin
            wstrb_q <= '1;
         end
      end else if (w_fire && !axi_wlast_o) begin
         if (((beat_cnt_q + 1'b1) == awlen_q) && last_burst_next) begin
            wstrb_q <= last_strb;
         end else begin
            wstrb_q <= '1;
         end
      end
   end

endmodule

// File: hw/word_count_gate.sv
`timescale 1ns/100ps

module word_count_gate (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  axi_write_pkg::slen_t count_i,
   input  logic                 load_i,
   input  logic                 src_valid_i,
   input  logic                 sink_ready_i,
   output logic                 src_ready_o,
   output logic                 pass_valid_o,
   output logic                 last_o,
   output logic                 done_o
);

   axi_write_pkg::slen_t count_q;
   logic                 working_q;
   logic                 word_fire;

   // Both directions closed while idle
   assign src_ready_o  = working_q & sink_ready_i;
   assign pass_valid_o = working_q & src_valid_i;
   assign word_fire    = src_valid_i & src_ready_o;

   assign last_o = working_q && (count_q == axi_write_pkg::slen_t'(1));
   assign done_o = ~working_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         count_q   <= '0;
         working_q <= 1'b0;
      end else if (working_q) begin
         if (word_fire) begin
            count_q <= count_q - axi_write_pkg::slen_t'(1);
            if (count_q == axi_write_pkg::slen_t'(1)) begin
               working_q <= 1'b0;  // Final word through
            end
         end
      end else if (load_i && (count_i != '0)) begin
         // A load while busy is ignored
         count_q   <= count_i;
         working_q <= 1'b1;
      end
   end

endmodule

// File: list.f
+incdir+hw
hw/axi_write_pkg.sv
hw/word_count_gate.sv
hw/byte_realign.sv
hw/axi_transfer_controller.sv
hw/simple_axi_write.sv
testbench/axi_write_checker.sv
testbench/tb_simple_axi_write.sv

// File: testbench/axi_write_checker.sv
`timescale 1ns/100ps
`include "axi_write_defs.svh"

module axi_write_checker (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  m_wvalid_i,
   input  logic                  m_wready_i,
   input  logic                  m_wlast_i,
   input  axi_write_pkg::addr_t  awaddr_i,
   input  axi_write_pkg::axlen_t awlen_i,
   input  logic [2:0]            awsize_i,
   input  logic [1:0]            awburst_i,
   input  logic                  awvalid_i,
   input  logic                  awready_i,
   input  axi_write_pkg::data_t  wdata_i,
   input  axi_write_pkg::strb_t  wstrb_i,
   input  logic                  wlast_i,
   input  logic                  wvalid_i,
   input  logic                  wready_i,
   output int                    errors_o
);

   // Expected traffic filled per request
   axi_write_pkg::addr_t  exp_addr_q[$];
   axi_write_pkg::axlen_t exp_len_q[$];
   axi_write_pkg::data_t  exp_data_q[$];
   axi_write_pkg::strb_t  exp_strb_q[$];
   logic                  exp_last_q[$];
   int                    src_words_q[$];
   int                    src_seen;
   int                    beats_left;
   int                    errors;

   axi_write_pkg::data_t  exp_data;
   axi_write_pkg::data_t  lane_mask;
   axi_write_pkg::strb_t  exp_strb;
   logic                  exp_last;

   assign errors_o = errors;

   initial begin
      src_seen   = 0;
      beats_left = 0;
      errors     = 0;
   end

   function automatic logic [7:0] pattern_byte(int base, int idx);
      return 8'(base * 37 + idx * 11 + 1);
   endfunction

   // Expands a request into bursts and beats at the address offset
   function automatic void expand_request(axi_write_pkg::addr_t addr, int len, int base);
      int off;
      int rem;
      int n;
      int bound;
      int k;
      int j;
      int l;
      int idx;
      axi_write_pkg::addr_t a;
      axi_write_pkg::data_t d;
      axi_write_pkg::strb_t s;
      off = addr % `AW_STRB_W;
      rem = (off + len + `AW_STRB_W - 1) / `AW_STRB_W;
      a   = addr - off;
      k   = 0;
      src_words_q.push_back((len + `AW_STRB_W - 1) / `AW_STRB_W);
      while (rem > 0) begin
         bound = (`AW_BOUNDARY - (a % `AW_BOUNDARY)) / `AW_STRB_W;
         n = `AW_MAX_BEATS;
         if (rem < n) n = rem;
         if (bound < n) n = bound;  // Stop at the 4 KB line
         exp_addr_q.push_back(a);
         exp_len_q.push_back(axi_write_pkg::axlen_t'(n - 1));
         for (j = 0; j < n; j++) begin
            d = '0;
            s = '0;
            for (l = 0; l < `AW_STRB_W; l++) begin
               idx = k * `AW_STRB_W + l - off;
               if (idx >= 0 && idx < len) begin
                  s[l]       = 1'b1;
                  d[8*l +: 8] = pattern_byte(base, idx);
               end
            end
            exp_data_q.push_back(d);
            exp_strb_q.push_back(s);
            exp_last_q.push_back(j == n - 1);
            k++;
         end
         beats_left += n;
         a   += n * `AW_STRB_W;
         rem -= n;
      end
   endfunction

   task automatic wrong_value(string name, logic [31:0] expv, logic [31:0] actv);
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expv, actv);
      errors++;
   endtask

   task automatic complain(string msg);
      $display("error at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_leftovers();
      if (exp_addr_q.size() != 0) complain("expected AW bursts never issued");
      if (exp_data_q.size() != 0) complain("expected W beats missing");
      if (src_words_q.size() != 0) complain("source words not all accepted");
   endtask

   always @(posedge clk_i) begin
      if (!rst_i) begin
         if ((awvalid_i || wvalid_i) && beats_left == 0)
            complain("valid raised with no request pending");
         if (awvalid_i && awready_i) begin
            if (exp_addr_q.size() == 0) begin
               complain("extra AW handshake");
            end else begin
               if (awaddr_i !== exp_addr_q[0])
                  wrong_value("axi_awaddr_o", exp_addr_q[0], awaddr_i);
               if (awlen_i !== exp_len_q[0]) wrong_value("axi_awlen_o", exp_len_q[0], awlen_i);
               if (awsize_i !== 3'd2) wrong_value("axi_awsize_o", 3'd2, awsize_i);
               if (awburst_i !== 2'b01) wrong_value("axi_awburst_o", 2'b01, awburst_i);
               void'(exp_addr_q.pop_front());
               void'(exp_len_q.pop_front());
            end
         end
         if (wvalid_i && wready_i) begin
            if (exp_data_q.size() == 0) begin
               complain("extra W beat");
            end else begin
               exp_data = exp_data_q.pop_front();
               exp_strb = exp_strb_q.pop_front();
               exp_last = exp_last_q.pop_front();
               for (int l = 0; l < `AW_STRB_W; l++) lane_mask[8*l +: 8] = {8{exp_strb[l]}};
               if (wstrb_i !== exp_strb) wrong_value("axi_wstrb_o", exp_strb, wstrb_i);
               if ((wdata_i & lane_mask) !== exp_data)
                  wrong_value("axi_wdata_o", exp_data, wdata_i & lane_mask);
               if (wlast_i !== exp_last) wrong_value("axi_wlast_o", exp_last, wlast_i);
               beats_left--;
            end
         end
         if (m_wvalid_i && m_wready_i) begin
            // Source words pass straight through to a W beat
            if (!(wvalid_i && wready_i))
               complain("source word accepted without a W beat");
            if (src_words_q.size() == 0) begin
               complain("source word accepted with no request");
            end else begin
               if (m_wlast_i !== (src_seen == src_words_q[0] - 1))
                  wrong_value("m_wlast_o", src_seen == src_words_q[0] - 1, m_wlast_i);
               src_seen++;
               if (src_seen == src_words_q[0]) begin  // Request fully consumed
                  void'(src_words_q.pop_front());
                  src_seen = 0;
               end
            end
         end
      end
   end

endmodule

// File: testbench/tb_simple_axi_write.sv
`timescale 1ns/100ps
`include "axi_write_defs.svh"

module tb_simple_axi_write;

   logic                  clk_i;
   logic                  rst_i;
   logic                  m_wvalid_i;
   axi_write_pkg::addr_t  m_waddr_i;
   axi_write_pkg::slen_t  m_wlen_i;
   axi_write_pkg::data_t  m_wdata_i;
   logic                  m_wready_o;
   logic                  m_wlast_o;
   axi_write_pkg::addr_t  axi_awaddr_o;
   axi_write_pkg::axlen_t axi_awlen_o;
   logic [2:0]            axi_awsize_o;
   logic [1:0]            axi_awburst_o;
   logic                  axi_awvalid_o;
   logic                  axi_awready_i;
   axi_write_pkg::data_t  axi_wdata_o;
   axi_write_pkg::strb_t  axi_wstrb_o;
   logic                  axi_wlast_o;
   logic                  axi_wvalid_o;
   logic                  axi_wready_i;
   int                    errors;
   int                    seed;
   int                    limit_cycles;

   // Aligned, unaligned, split, 4 KB crossing, extra beat cases
   axi_write_pkg::addr_t req_addr [0:8] = '{32'h100, 32'h201, 32'h303, 32'h402, 32'h1000,
                                            32'h1fe2, 32'h2ff1, 32'h503, 32'h600};
   int                   req_len [0:8]  = '{32, 10, 6, 1, 100, 60, 200, 3, 68};

   simple_axi_write simple_axi_write_i (.*);

   axi_write_checker axi_write_checker_i (
      .clk_i (clk_i), .rst_i (rst_i),
      .m_wvalid_i (m_wvalid_i), .m_wready_i (m_wready_o), .m_wlast_i (m_wlast_o),
      .awaddr_i (axi_awaddr_o), .awlen_i (axi_awlen_o), .awsize_i (axi_awsize_o),
      .awburst_i (axi_awburst_o), .awvalid_i (axi_awvalid_o), .awready_i (axi_awready_i),
      .wdata_i (axi_wdata_o), .wstrb_i (axi_wstrb_o), .wlast_i (axi_wlast_o),
      .wvalid_i (axi_wvalid_o), .wready_i (axi_wready_i), .errors_o (errors)
   );

   always #5 clk_i = ~clk_i;

   // Slave model accepts AW once seen and drives random wready
   always @(negedge clk_i) begin
      axi_awready_i = axi_awvalid_o;
      axi_wready_i  = ($random(seed) & 3) != 0;
   end

   function automatic logic [7:0] pattern_byte(int base, int idx);
      return 8'(base * 37 + idx * 11 + 1);
   endfunction

   // Starts and ends on a falling edge
   task automatic run_request(axi_write_pkg::addr_t addr, int len, int base);
      int words;
      int n;
      int l;
      logic accepted;
      axi_write_pkg::data_t w;
      axi_write_checker_i.expand_request(addr, len, base);
      words     = (len + 3) / 4;
      m_waddr_i = addr;
      m_wlen_i  = axi_write_pkg::slen_t'(len);
      for (n = 0; n < words; n++) begin
         for (l = 0; l < 4; l++) begin
            w[8*l +: 8] = pattern_byte(base, n * 4 + l);  // Tail bytes carry junk too
         end
         m_wdata_i  = w;
         m_wvalid_i = 1'b1;
         accepted   = 1'b0;
         while (!accepted) begin
            #1;
            accepted = m_wready_o;  // Settled mid low phase
            @(negedge clk_i);
         end
      end
      m_wvalid_i = 1'b0;
      m_wdata_i  = '0;
      while (axi_write_checker_i.beats_left != 0) @(negedge clk_i);
      repeat (4) @(negedge clk_i);  // Idle gap between requests
   endtask

   initial begin
      clk_i         = 1'b0;
      rst_i         = 1'b1;
      m_wvalid_i    = 1'b0;
      m_waddr_i     = '0;
      m_wlen_i      = '0;
      m_wdata_i     = '0;
      axi_awready_i = 1'b0;
      axi_wready_i  = 1'b0;
      seed          = 32'h40c8e360;
      limit_cycles  = 0;
      for (int r = 0; r < 9; r++)
         limit_cycles += 20 * ((req_addr[r] % 4 + req_len[r] + 3) / 4) + 100;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      repeat (3) @(negedge clk_i);
      for (int r = 0; r < 9; r++) run_request(req_addr[r], req_len[r], r);
      axi_write_checker_i.check_leftovers();
      @(negedge clk_i);  // Count reaches the checker port
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #1;
      repeat (limit_cycles) @(posedge clk_i);
      $display("timeout: run did not finish within %0d cycles, errors: %0d",
               limit_cycles, errors);
      $display("tests failed");
      $finish;
   end

endmodule
